/* run_sim.sh */
#!/bin/sh
# Build and run the EX stage testbench with Verilator

verilator --binary --timing --assert --top-module tb_ex_stage -f vlog.f \
        -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log

grep -q "^Finished with no errors$" sim.log && echo "Simulation passed" || {
        echo "Simulation failed"; exit 1; }

/* source/ex_alu.sv */
module ex_alu #(
        parameter int DATA_W = ex_pkg::DATA_W
) (
        input  logic                    clk,
        input  logic                    i_arst_n,
        input  logic [DATA_W-1:0]       i_op1,
        input  logic [DATA_W-1:0]       i_op2,
        input  ex_pkg::alu_op_e         i_op,
        input  logic                    i_cc_we,
        input  logic                    i_valid,
        input  logic                    i_stall,
        output logic [DATA_W-1:0]       o_alu_rslt,
        output logic [ex_pkg::CC_W-1:0] o_ccodes
);

        localparam int SH_W = $clog2(DATA_W);

        logic                    sub_mode;
        logic [DATA_W-1:0]       op2_inv;
        logic [DATA_W:0]         sum;       // Extra bit is the carry out
        logic                    ovf;
        logic                    is_arith;
        logic [SH_W-1:0]         shamt;
        logic                    cc_upd;
        logic [ex_pkg::CC_W-1:0] cc_d;
        logic [ex_pkg::CC_W-1:0] cc_q;

        ////////////////////
        // Adder
        ////////////////////

        assign sub_mode = (i_op == ex_pkg::SUB) || (i_op == ex_pkg::SLT) ||
                          (i_op == ex_pkg::SLTU);
        assign op2_inv  = sub_mode ? ~i_op2 : i_op2;
        assign sum      = {1'b0, i_op1} + {1'b0, op2_inv} + {{DATA_W{1'b0}}, sub_mode};
        assign ovf      = (i_op1[DATA_W-1] == op2_inv[DATA_W-1]) &&
                          (sum[DATA_W-1] != i_op1[DATA_W-1]);
        assign shamt    = i_op2[SH_W-1:0];

        always_comb begin
                case (i_op)
                        ex_pkg::ADD,
                        ex_pkg::SUB:    o_alu_rslt = sum[DATA_W-1:0];
                        ex_pkg::AND:    o_alu_rslt = i_op1 & i_op2;
                        ex_pkg::OR:     o_alu_rslt = i_op1 | i_op2;
                        ex_pkg::XOR:    o_alu_rslt = i_op1 ^ i_op2;
                        ex_pkg::SLL:    o_alu_rslt = i_op1 << shamt;
                        ex_pkg::SRL:    o_alu_rslt = i_op1 >> shamt;
                        ex_pkg::SRA:    o_alu_rslt = $signed(i_op1) >>> shamt;
                        ex_pkg::SLT:    o_alu_rslt = {{(DATA_W-1){1'b0}}, sum[DATA_W-1] ^ ovf};
                        ex_pkg::SLTU:   o_alu_rslt = {{(DATA_W-1){1'b0}}, ~sum[DATA_W]};
                        ex_pkg::PASS_B: o_alu_rslt = i_op2;
                        default:        o_alu_rslt = '0;
                endcase
        end

        ////////////////////
        // Condition codes
        ////////////////////

        assign is_arith = (i_op == ex_pkg::ADD) || (i_op == ex_pkg::SUB);
        assign cc_upd   = i_cc_we && i_valid && !i_stall;   // Bubbles and held slots keep flags

        always_comb begin
                cc_d             = '0;
                cc_d[ex_pkg::CC_N] = o_alu_rslt[DATA_W-1];
                cc_d[ex_pkg::CC_Z] = (o_alu_rslt == '0);
                cc_d[ex_pkg::CC_C] = is_arith & sum[DATA_W];   // Set means no borrow on SUB
                cc_d[ex_pkg::CC_V] = is_arith & ovf;
        end

        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        cc_q <= '0;
                end else if (cc_upd) begin
                        cc_q <= cc_d;
                end
        end

        assign o_ccodes = cc_q;

        // No flag write from an undefined opcode
        a_op_legal: assert property (@(posedge clk) disable iff (!i_arst_n)
                cc_upd |-> (i_op <= ex_pkg::PASS_B));

endmodule

/* source/ex_branch_resolve.sv */
module ex_branch_resolve #(
        parameter int DATA_W = ex_pkg::DATA_W
) (
        input  logic                    clk,
        input  logic                    i_arst_n,
        input  logic                    i_valid,
        input  logic                    i_jump,
        input  logic                    i_branch,
        input  ex_pkg::cond_e           i_cond,
        input  logic [ex_pkg::CC_W-1:0] i_ccodes,
        input  logic [DATA_W-1:0]       i_pc,
        input  logic [DATA_W-1:0]       i_target,
        input  logic                    i_target_from_alu,
        input  logic [DATA_W-1:0]       i_alu_rslt,
        input  logic [DATA_W-1:0]       i_ppc,
        output logic                    o_taken,
        output logic [DATA_W-1:0]       o_new_pc,
        output logic                    o_mispredict
);

        logic              n_f, z_f, c_f, v_f;
        logic              cond_ok;
        logic [DATA_W-1:0] target;

        assign n_f = i_ccodes[ex_pkg::CC_N];
        assign z_f = i_ccodes[ex_pkg::CC_Z];
        assign c_f = i_ccodes[ex_pkg::CC_C];
        assign v_f = i_ccodes[ex_pkg::CC_V];

        // Flags come from the register, not this cycle's ALU result
        always_comb begin
                case (i_cond)
                        ex_pkg::ALWAYS: cond_ok = 1'b1;
                        ex_pkg::EQ:     cond_ok = z_f;
                        ex_pkg::NE:     cond_ok = !z_f;
                        ex_pkg::LT:     cond_ok = n_f != v_f;
                        ex_pkg::GE:     cond_ok = n_f == v_f;
                        ex_pkg::LTU:    cond_ok = !c_f;
                        ex_pkg::GEU:    cond_ok = c_f;
                        default:        cond_ok = 1'b0;     // NEVER
                endcase
        end

        assign target       = i_target_from_alu ? i_alu_rslt : i_target;  // Register-indirect jumps
        assign o_taken      = i_jump || (i_branch && cond_ok);
        assign o_new_pc     = o_taken ? target : i_pc + DATA_W'(4);
        assign o_mispredict = i_valid && (o_new_pc != i_ppc);

        a_jmp_bxx_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
                i_valid |-> !(i_jump && i_branch));

endmodule

/* source/ex_ma_reg.sv */
module ex_ma_reg #(
        parameter int DATA_W     = ex_pkg::DATA_W,
        parameter int REG_ADDR_W = ex_pkg::REG_ADDR_W
) (
        input  logic                         clk,
        input  logic                         i_arst_n,
        input  logic                         i_stall,
        input  logic                         i_flush,
        input  logic                         i_valid,
        input  logic [ex_pkg::WB_CTRL_W-1:0] i_wb_ctrl,
        input  logic [ex_pkg::MA_CTRL_W-1:0] i_ma_ctrl,
        input  logic [DATA_W-1:0]            i_alu_rslt,
        input  logic [DATA_W-1:0]            i_store_data,
        input  logic [DATA_W-1:0]            i_pc,
        input  logic [REG_ADDR_W-1:0]        i_rd_addr,
        output logic                         o_exma_valid,
        output logic [ex_pkg::WB_CTRL_W-1:0] o_exma_wb_ctrl,
        output logic [ex_pkg::MA_CTRL_W-1:0] o_exma_ma_ctrl,
        output logic [DATA_W-1:0]            o_exma_alu_rslt,
        output logic [DATA_W-1:0]            o_exma_store_data,
        output logic [DATA_W-1:0]            o_exma_pc,
        output logic [REG_ADDR_W-1:0]        o_exma_rd_addr
);

        ////////////////////
        // Control fields
        ////////////////////

        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_exma_valid   <= 1'b0;
                        o_exma_wb_ctrl <= '0;
                        o_exma_ma_ctrl <= '0;
                end else if (i_flush) begin     // Wins over stall
                        o_exma_valid   <= 1'b0;
                        o_exma_wb_ctrl <= '0;
                        o_exma_ma_ctrl <= '0;
                end else if (!i_stall) begin
                        o_exma_valid   <= i_valid;
                        o_exma_wb_ctrl <= i_wb_ctrl;
                        o_exma_ma_ctrl <= i_ma_ctrl;
                end
        end

        // Payload, meaningless while valid is low
        always_ff @(posedge clk) begin
                if (!i_stall) begin
                        o_exma_alu_rslt   <= i_alu_rslt;
                        o_exma_store_data <= i_store_data;
                        o_exma_pc         <= i_pc;
                        o_exma_rd_addr    <= i_rd_addr;
                end
        end

        a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
                (i_stall && !i_flush) |=> $stable(o_exma_valid));

endmodule

/* source/ex_operand_select.sv */
module ex_operand_select #(
        parameter int DATA_W = ex_pkg::DATA_W
) (
        input  logic [DATA_W-1:0]  i_rs1,
        input  logic [DATA_W-1:0]  i_rs2,
        input  logic [DATA_W-1:0]  i_data_mem,
        input  logic [DATA_W-1:0]  i_data_wb,
        input  logic [DATA_W-1:0]  i_data_vwb,
        input  logic [DATA_W-1:0]  i_imm,
        input  logic [DATA_W-1:0]  i_pc,
        input  ex_pkg::fwd_sel_e   i_fwd1,
        input  ex_pkg::fwd_sel_e   i_fwd2,
        input  ex_pkg::src1_sel_e  i_src1,
        input  logic               i_src2_imm,
        output logic [DATA_W-1:0]  o_op1,
        output logic [DATA_W-1:0]  o_op2,
        output logic [DATA_W-1:0]  o_store_data
);

        logic [DATA_W-1:0] rs1_fwd;
        logic [DATA_W-1:0] rs2_fwd;

        // Bypass mux shared by both operands
        function automatic logic [DATA_W-1:0] fwd_pick(input ex_pkg::fwd_sel_e sel,
                                                       input logic [DATA_W-1:0] reg_val);
                case (sel)
                        ex_pkg::MEM: fwd_pick = i_data_mem;
                        ex_pkg::WB:  fwd_pick = i_data_wb;
                        ex_pkg::VWB: fwd_pick = i_data_vwb;
                        default:     fwd_pick = reg_val;
                endcase
        endfunction

        assign rs1_fwd = fwd_pick(i_fwd1, i_rs1);
        assign rs2_fwd = fwd_pick(i_fwd2, i_rs2);

        always_comb begin
                case (i_src1)
                        ex_pkg::RS1: o_op1 = rs1_fwd;
                        ex_pkg::PC:  o_op1 = i_pc;      // PC-relative targets
                        default:     o_op1 = '0;
                endcase
        end

        assign o_op2        = i_src2_imm ? i_imm : rs2_fwd;
        assign o_store_data = rs2_fwd;    // Stores always take rs2, even with an immediate

endmodule

/* source/ex_pkg.sv */
package ex_pkg;

        ////////////////////
        // Widths
        ////////////////////

        localparam int DATA_W     = 32;    // Data and PC
        localparam int REG_ADDR_W = 5;
        localparam int WB_CTRL_W  = 2;     // Writeback control bundle
        localparam int MA_CTRL_W  = 3;     // Memory access control bundle
        localparam int CC_W       = 4;

        // Flag positions in the condition code vector
        localparam int CC_N = 3;
        localparam int CC_Z = 2;
        localparam int CC_C = 1;
        localparam int CC_V = 0;

        ////////////////////
        // Encodings
        ////////////////////

        typedef enum logic [3:0] {
                ADD    = 4'd0,
                SUB    = 4'd1,
                AND    = 4'd2,
                OR     = 4'd3,
                XOR    = 4'd4,
                SLL    = 4'd5,
                SRL    = 4'd6,
                SRA    = 4'd7,
                SLT    = 4'd8,
                SLTU   = 4'd9,
                PASS_B = 4'd10     // Operand 2 straight through
        } alu_op_e;

        typedef enum logic [1:0] {
                REG = 2'd0,        // Register file value
                MEM = 2'd1,
                WB  = 2'd2,
                VWB = 2'd3         // Writeback, one cycle late
        } fwd_sel_e;

        typedef enum logic [1:0] {
                RS1  = 2'd0,
                PC   = 2'd1,
                ZERO = 2'd2
        } src1_sel_e;

        typedef enum logic [3:0] {
                ALWAYS = 4'd0,
                EQ     = 4'd1,
                NE     = 4'd2,
                LT     = 4'd3,
                GE     = 4'd4,
                LTU    = 4'd5,
                GEU    = 4'd6,
                NEVER  = 4'd7
        } cond_e;

endpackage

/* source/ex_stage.sv */
module ex_stage #(
        parameter int DATA_W     = ex_pkg::DATA_W,
        parameter int REG_ADDR_W = ex_pkg::REG_ADDR_W
) (
        input  logic                         clk,
        input  logic                         i_arst_n,
        // Operands and forwarding
        input  logic [DATA_W-1:0]            i_rs1,
        input  logic [DATA_W-1:0]            i_rs2,
        input  logic [DATA_W-1:0]            i_data_mem,
        input  logic [DATA_W-1:0]            i_data_wb,
        input  logic [DATA_W-1:0]            i_data_vwb,
        input  logic [DATA_W-1:0]            i_imm,
        input  logic [DATA_W-1:0]            i_pc,
        input  ex_pkg::fwd_sel_e             i_fwd1,
        input  ex_pkg::fwd_sel_e             i_fwd2,
        input  ex_pkg::src1_sel_e            i_src1,
        input  logic                         i_src2_imm,
        // ALU control
        input  ex_pkg::alu_op_e              i_alu_op,
        input  logic                         i_cc_we,
        // Branch unit
        input  logic                         i_jump,
        input  logic                         i_branch,
        input  ex_pkg::cond_e                i_cond,
        input  logic [DATA_W-1:0]            i_target,
        input  logic                         i_target_from_alu,
        input  logic [DATA_W-1:0]            i_ppc,
        // Pipeline control and pass-through fields
        input  logic                         i_valid,
        input  logic                         i_stall,
        input  logic                         i_flush,
        input  logic [REG_ADDR_W-1:0]        i_rd_addr,
        input  logic [ex_pkg::WB_CTRL_W-1:0] i_wb_ctrl,
        input  logic [ex_pkg::MA_CTRL_W-1:0] i_ma_ctrl,
        output logic [DATA_W-1:0]            o_alu_rslt,
        output logic [ex_pkg::CC_W-1:0]      o_ccodes,
        output logic [DATA_W-1:0]            o_new_pc,
        output logic                         o_taken,
        output logic                         o_mispredict,
        // EX/MA register
        output logic                         o_exma_valid,
        output logic [ex_pkg::WB_CTRL_W-1:0] o_exma_wb_ctrl,
        output logic [ex_pkg::MA_CTRL_W-1:0] o_exma_ma_ctrl,
        output logic [DATA_W-1:0]            o_exma_alu_rslt,
        output logic [DATA_W-1:0]            o_exma_store_data,
        output logic [DATA_W-1:0]            o_exma_pc,
        output logic [REG_ADDR_W-1:0]        o_exma_rd_addr
);

        logic [DATA_W-1:0] op1;
        logic [DATA_W-1:0] op2;
        logic [DATA_W-1:0] store_data;

        ex_operand_select #(.DATA_W(DATA_W)) opsel_i (
                .i_rs1(i_rs1), .i_rs2(i_rs2), .i_data_mem(i_data_mem),
                .i_data_wb(i_data_wb), .i_data_vwb(i_data_vwb), .i_imm(i_imm),
                .i_pc(i_pc), .i_fwd1(i_fwd1), .i_fwd2(i_fwd2), .i_src1(i_src1),
                .i_src2_imm(i_src2_imm), .o_op1(op1), .o_op2(op2),
                .o_store_data(store_data)
        );

        ex_alu #(.DATA_W(DATA_W)) alu_i (
                .clk(clk), .i_arst_n(i_arst_n), .i_op1(op1), .i_op2(op2),
                .i_op(i_alu_op), .i_cc_we(i_cc_we), .i_valid(i_valid),
                .i_stall(i_stall), .o_alu_rslt(o_alu_rslt), .o_ccodes(o_ccodes)
        );

        ex_branch_resolve #(.DATA_W(DATA_W)) br_i (
                .clk(clk), .i_arst_n(i_arst_n), .i_valid(i_valid), .i_jump(i_jump),
                .i_branch(i_branch), .i_cond(i_cond), .i_ccodes(o_ccodes), .i_pc(i_pc),
                .i_target(i_target), .i_target_from_alu(i_target_from_alu),
                .i_alu_rslt(o_alu_rslt), .i_ppc(i_ppc), .o_taken(o_taken),
                .o_new_pc(o_new_pc), .o_mispredict(o_mispredict)
        );

        ex_ma_reg #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) exma_i (
                .clk(clk), .i_arst_n(i_arst_n), .i_stall(i_stall), .i_flush(i_flush),
                .i_valid(i_valid), .i_wb_ctrl(i_wb_ctrl), .i_ma_ctrl(i_ma_ctrl),
                .i_alu_rslt(o_alu_rslt), .i_store_data(store_data), .i_pc(i_pc),
                .i_rd_addr(i_rd_addr), .o_exma_valid(o_exma_valid),
                .o_exma_wb_ctrl(o_exma_wb_ctrl), .o_exma_ma_ctrl(o_exma_ma_ctrl),
                .o_exma_alu_rslt(o_exma_alu_rslt), .o_exma_store_data(o_exma_store_data),
                .o_exma_pc(o_exma_pc), .o_exma_rd_addr(o_exma_rd_addr)
        );

endmodule

/* test/ex_stim.hex */
// test ctrl rs1 rs2 mem wb vwb imm pc target ppc | alu new_pc flags(cc<<4,mis,taken)
// | exma_ctrl(ma,wb,valid) exma_alu exma_store exma_pc exma_rd
1 49480000 7 5 11 22 33 44 64 C8 68 C 68 0 13 C 5 64 5
2 49480001 5 7 11 22 33 44 64 C8 68 FFFFFFFE 68 0 13 FFFFFFFE 7 64 5
3 49480002 F0F0 FF00 11 22 33 44 64 C8 68 F000 68 0 13 F000 FF00 64 5
4 49480003 F0F0 FF00 11 22 33 44 64 C8 68 FFF0 68 0 13 FFF0 FF00 64 5
5 49480004 F0F0 FF00 11 22 33 44 64 C8 68 FF0 68 0 13 FF0 FF00 64 5
6 49480005 1 24 11 22 33 44 64 C8 68 10 68 0 13 10 24 64 5
7 49480006 80000000 3F 11 22 33 44 64 C8 68 1 68 0 13 1 3F 64 5
8 49480007 80000000 4 11 22 33 44 64 C8 68 F8000000 68 0 13 F8000000 4 64 5
9 49480008 FFFFFFFF 1 11 22 33 44 64 C8 68 1 68 0 13 1 1 64 5
A 49480009 FFFFFFFF 1 11 22 33 44 64 C8 68 0 68 0 13 0 1 64 5
B 4948000A 1234 ABCD 11 22 33 44 64 C8 68 ABCD 68 0 13 ABCD ABCD 64 5
// Forwarding and source selects
C 49480090 1 2 11 22 33 44 64 C8 68 33 68 0 13 33 22 64 5
D 49480070 1 2 11 22 33 44 64 C8 68 44 68 0 13 44 11 64 5
E 494800E0 1 2 11 22 33 44 64 C8 68 55 68 0 13 55 33 64 5
F 49480500 5 9 11 22 33 44 64 C8 68 A8 68 0 13 A8 9 64 5
10 49480200 5 77 11 22 33 44 64 C8 68 77 68 0 13 77 77 64 5
// Condition codes
11 49480801 5 5 11 22 33 44 64 C8 68 0 68 0 13 0 5 64 5
12 49400800 80000000 80000000 11 22 33 44 64 C8 68 0 68 60 12 0 0 0 0
13 49580800 7FFFFFFF 1 11 22 33 44 64 C8 68 80000000 68 60 12 0 0 0 0
14 49480800 7FFFFFFF 1 11 22 33 44 64 C8 68 80000000 68 60 13 80000000 1 64 5
15 49480800 FFFFFFFF 1 11 22 33 44 64 C8 68 0 68 90 13 0 1 64 5
16 49480802 80000000 FFFFFFFF 11 22 33 44 64 C8 68 80000000 68 60 13 80000000 FFFFFFFF 64 5
// Branches with N set, Z C V clear
17 49486000 0 0 11 22 33 44 64 C8 68 0 68 80 13 0 0 64 5
18 4948A000 0 0 11 22 33 44 64 C8 68 0 C8 83 13 0 0 64 5
19 4948E000 0 0 11 22 33 44 64 C8 C8 0 C8 81 13 0 0 64 5
1A 49492000 0 0 11 22 33 44 64 C8 C8 0 68 82 13 0 0 64 5
1B 49496000 0 0 11 22 33 44 64 C8 68 0 C8 83 13 0 0 64 5
1C 4949A000 0 0 11 22 33 44 64 C8 68 0 68 80 13 0 0 64 5
1D 4949E000 0 0 11 22 33 44 64 C8 68 0 68 80 13 0 0 64 5
1E 49481000 0 0 11 22 33 44 64 C8 C8 0 C8 81 13 0 0 64 5
1F 494C1000 1000 20 11 22 33 44 64 C8 68 1020 1020 83 13 1020 20 64 5
20 4940A000 0 0 11 22 33 44 64 C8 68 0 C8 81 12 0 0 0 0
// EX/MA stall and flush
21 49480000 10 20 11 22 33 44 200 C8 204 30 204 80 13 30 20 200 5
22 49580000 1 1 11 22 33 44 300 C8 304 2 304 80 13 30 20 200 5
23 49580000 2 2 11 22 33 44 300 C8 304 4 304 80 13 30 20 200 5
24 49780000 3 3 11 22 33 44 300 C8 304 6 304 80 0 0 0 0 0
25 B2480004 FF F 11 22 33 44 300 C8 304 F0 304 80 2D F0 F 300 9
26 49680000 1 2 11 22 33 44 64 C8 68 3 68 80 0 0 0 0 0

/* test/tb_ex_stage.sv */
module tb_ex_stage;

        localparam int DATA_W     = ex_pkg::DATA_W;
        localparam int REG_ADDR_W = ex_pkg::REG_ADDR_W;
        localparam int VEC_N      = 38;
        localparam int VEC_WORDS  = 19;     // Words per stim line
        localparam int CLK_PER    = 20;
        localparam int RST_CYC    = 5;
        localparam int RST_VEC    = 16;     // Valid SUB with flag write, held during reset

        logic                         clk = 1'b0;
        logic                         i_arst_n;
        logic [DATA_W-1:0]            i_rs1, i_rs2, i_data_mem, i_data_wb, i_data_vwb;
        logic [DATA_W-1:0]            i_imm, i_pc, i_target, i_ppc;
        ex_pkg::fwd_sel_e             i_fwd1, i_fwd2;
        ex_pkg::src1_sel_e            i_src1;
        logic                         i_src2_imm;
        ex_pkg::alu_op_e              i_alu_op;
        logic                         i_cc_we, i_jump, i_branch, i_target_from_alu;
        ex_pkg::cond_e                i_cond;
        logic                         i_valid, i_stall, i_flush;
        logic [REG_ADDR_W-1:0]        i_rd_addr;
        logic [ex_pkg::WB_CTRL_W-1:0] i_wb_ctrl;
        logic [ex_pkg::MA_CTRL_W-1:0] i_ma_ctrl;
        logic [DATA_W-1:0]            o_alu_rslt, o_new_pc;
        logic [ex_pkg::CC_W-1:0]      o_ccodes;
        logic                         o_taken, o_mispredict, o_exma_valid;
        logic [ex_pkg::WB_CTRL_W-1:0] o_exma_wb_ctrl;
        logic [ex_pkg::MA_CTRL_W-1:0] o_exma_ma_ctrl;
        logic [DATA_W-1:0]            o_exma_alu_rslt, o_exma_store_data, o_exma_pc;
        logic [REG_ADDR_W-1:0]        o_exma_rd_addr;

        logic [31:0] stim_mem [0:VEC_N*VEC_WORDS-1];
        int          err_count  = 0;
        int          test_errs  = 0;
        int          fail_tests = 0;

        always #(CLK_PER/2) clk = ~clk;

        ex_stage #(.DATA_W(DATA_W), .REG_ADDR_W(REG_ADDR_W)) ex_stage_i (.*);

        ////////////////////
        // Helpers
        ////////////////////

        task automatic check_val(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
                if (act !== exp) begin
                        $display("mismatch %s: expected %h, actual %h", name, exp, act);
                        err_count++;
                        test_errs++;
                end
        endtask

        // Unpack one line of the stim file onto the DUT inputs
        task automatic drive_vec(input int base);
                logic [31:0] ctrl;
                ctrl              = stim_mem[base+1];
                i_alu_op          = ex_pkg::alu_op_e'(ctrl[3:0]);
                i_fwd1            = ex_pkg::fwd_sel_e'(ctrl[5:4]);
                i_fwd2            = ex_pkg::fwd_sel_e'(ctrl[7:6]);
                i_src1            = ex_pkg::src1_sel_e'(ctrl[9:8]);
                i_src2_imm        = ctrl[10];
                i_cc_we           = ctrl[11];
                i_jump            = ctrl[12];
                i_branch          = ctrl[13];
                i_cond            = ex_pkg::cond_e'(ctrl[17:14]);
                i_target_from_alu = ctrl[18];
                i_valid           = ctrl[19];
                i_stall           = ctrl[20];
                i_flush           = ctrl[21];
                i_rd_addr         = ctrl[26:22];
                i_wb_ctrl         = ctrl[28:27];
                i_ma_ctrl         = ctrl[31:29];
                i_rs1             = stim_mem[base+2];
                i_rs2             = stim_mem[base+3];
                i_data_mem        = stim_mem[base+4];
                i_data_wb         = stim_mem[base+5];
                i_data_vwb        = stim_mem[base+6];
                i_imm             = stim_mem[base+7];
                i_pc              = stim_mem[base+8];
                i_target          = stim_mem[base+9];
                i_ppc             = stim_mem[base+10];
        endtask

        task automatic check_comb(input int base, input int tnum);
                logic [31:0] flags;
                flags = stim_mem[base+13];
                check_val($sformatf("test %0d alu_rslt", tnum), stim_mem[base+11], o_alu_rslt);
                check_val($sformatf("test %0d new_pc", tnum), stim_mem[base+12], o_new_pc);
                check_val($sformatf("test %0d taken", tnum), {31'b0, flags[0]}, {31'b0, o_taken});
                check_val($sformatf("test %0d mispredict", tnum), {31'b0, flags[1]},
                          {31'b0, o_mispredict});
                check_val($sformatf("test %0d ccodes", tnum), {28'b0, flags[7:4]},
                          {28'b0, o_ccodes});
        endtask

        task automatic check_exma(input int base, input int tnum);
                logic [31:0] xctrl;
                xctrl = stim_mem[base+14];
                check_val($sformatf("test %0d exma_ctrl", tnum), xctrl,
                          {26'b0, o_exma_ma_ctrl, o_exma_wb_ctrl, o_exma_valid});
                // Payload only carries meaning with valid set
                if (xctrl[0]) begin
                        check_val($sformatf("test %0d exma_alu_rslt", tnum), stim_mem[base+15],
                                  o_exma_alu_rslt);
                        check_val($sformatf("test %0d exma_store_data", tnum), stim_mem[base+16],
                                  o_exma_store_data);
                        check_val($sformatf("test %0d exma_pc", tnum), stim_mem[base+17],
                                  o_exma_pc);
                        check_val($sformatf("test %0d exma_rd_addr", tnum), stim_mem[base+18],
                                  {27'b0, o_exma_rd_addr});
                end
        endtask

        ////////////////////
        // Main sequence
        ////////////////////

        initial begin
                int base;
                int tnum;
                $readmemh("test/ex_stim.hex", stim_mem);
                i_arst_n = 1'b0;
                drive_vec(RST_VEC * VEC_WORDS);    // Live instruction while reset is held
                repeat (RST_CYC) @(posedge clk);
                #2 i_arst_n = 1'b1;
                test_errs = 0;
                check_val("reset exma_ctrl", 32'h0,
                          {26'b0, o_exma_ma_ctrl, o_exma_wb_ctrl, o_exma_valid});
                check_val("reset ccodes", 32'h0, {28'b0, o_ccodes});
                if (test_errs == 0) begin
                        $display("test reset passed");
                end else begin
                        $display("test reset failed with %0d mismatches", test_errs);
                        fail_tests++;
                end
                i_valid  = 1'b0;
                i_cc_we  = 1'b0;
                @(posedge clk);
                #2;
                for (int i = 0; i < VEC_N; i++) begin
                        base      = i * VEC_WORDS;
                        tnum      = stim_mem[base];
                        test_errs = 0;
                        drive_vec(base);
                        #16 check_comb(base, tnum);    // Just before the edge
                        @(posedge clk);
                        #1 check_exma(base, tnum);
                        if (test_errs == 0) begin
                                $display("test %0d passed", tnum);
                        end else begin
                                $display("test %0d failed with %0d mismatches", tnum, test_errs);
                                fail_tests++;
                        end
                        #1;
                end
                $display("%0d tests run, %0d failed, %0d mismatches", VEC_N + 1, fail_tests,
                         err_count);
                if (err_count == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

        // Watchdog
        initial begin
                #(VEC_N * CLK_PER * 2 + (RST_CYC + 2) * CLK_PER);
                $display("Timeout: the vector loop did not complete in time");
                $display("Finished with errors");
                $finish;
        end

endmodule

/* vlog.f */
source/ex_pkg.sv
source/ex_operand_select.sv
source/ex_alu.sv
source/ex_branch_resolve.sv
source/ex_ma_reg.sv
source/ex_stage.sv
test/tb_ex_stage.sv
